// File: design/eth_link_pkg.sv
package eth_link_pkg;

   // ------------------------------------------------------------
   // Line widths
   // ------------------------------------------------------------

   // One line symbol
   localparam int sym_w = 10;
   // Transceiver word, two symbols
   localparam int gtx_w = 20;

   // ------------------------------------------------------------
   // Control codes
   // ------------------------------------------------------------

   localparam logic [3:0] ctl_idle = 4'd0;
   localparam logic [3:0] ctl_sof  = 4'd1;
   localparam logic [3:0] ctl_eof  = 4'd2;

   // Idle symbol, kind set and spare bits clear
   localparam logic [sym_w-1:0] sym_idle = {1'b1, 5'b00000, ctl_idle};

   // Symbol read as data or as control, selected by bit 9
   typedef union packed {
      // Data view, kind 0, odd parity over the byte
      struct packed {
         logic       kind;
         logic       parity;
         logic [7:0] data;
      } dat;
      // Control view, kind 1, spare must be zero
      struct packed {
         logic       kind;
         logic [4:0] spare;
         logic [3:0] code;
      } ctl;
   } line_symbol_t;

endpackage

// File: design/eth_frame_pkg.sv
package eth_frame_pkg;

   // Data bytes between SOF and EOF, command and reply alike
   localparam int cmd_len = 14;
   localparam int frame_w = 8 * cmd_len;

   // Byte offsets in the frame, multi-byte fields big-endian
   localparam int off_ip   = 0;
   localparam int off_port = 4;
   localparam int off_op   = 6;
   localparam int off_addr = 7;
   localparam int off_data = 10;

   // Configuration banks on cfg_addr[4]
   localparam logic sel_ipaddr = 1'b0;
   localparam logic sel_udp    = 1'b1;
   localparam int   ip_bytes   = 4;
   localparam int   port_bytes = 2;

   // Command engine sequence
   localparam logic [2:0] st_idle = 3'd0;
   localparam logic [2:0] st_bus  = 3'd1;
   localparam logic [2:0] st_cap  = 3'd2;
   localparam logic [2:0] st_sof  = 3'd3;
   localparam logic [2:0] st_data = 3'd4;
   localparam logic [2:0] st_eof  = 3'd5;

endpackage

// File: design/gtx_gearbox.sv
`timescale 1ns/1ns

module gtx_gearbox (
   input  logic                             cfg_clk,
   input  logic                             rst_n,
   input  logic [eth_link_pkg::gtx_w-1:0]   gtx_rxd,
   input  eth_link_pkg::line_symbol_t       tx_sym,
   output logic [eth_link_pkg::gtx_w-1:0]   gtx_txd,
   output eth_link_pkg::line_symbol_t       rx_sym,
   output logic                             rx_sym_valid
);

   // Word phase, zero on the first cycle out of reset
   logic                           phase;
   // Receive word held for two symbol cycles
   logic [eth_link_pkg::gtx_w-1:0] rx_word;
   // Earlier transmit symbol of the pair
   eth_link_pkg::line_symbol_t     tx_hold;

   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         phase <= 1'b0;
      end else begin
         phase <= ~phase;
      end
   end

   // ------------------------------------------------------------
   // Receive split
   // ------------------------------------------------------------

   always_ff @(posedge cfg_clk) begin
      if (!phase) begin
         rx_word <= gtx_rxd;
      end
   end

   // Valid once the first word is in
   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         rx_sym_valid <= 1'b0;
      end else if (!phase) begin
         rx_sym_valid <= 1'b1;
      end
   end

   // Low half first, high half on the following cycle
   assign rx_sym = phase ? rx_word[eth_link_pkg::sym_w-1:0]
                         : rx_word[eth_link_pkg::gtx_w-1:eth_link_pkg::sym_w];

   // ------------------------------------------------------------
   // Transmit pack
   // ------------------------------------------------------------

   always_ff @(posedge cfg_clk) begin
      if (!phase) begin
         tx_hold <= tx_sym;
      end
   end

   // New word seen on phase-zero cycles
   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         gtx_txd <= {eth_link_pkg::sym_idle, eth_link_pkg::sym_idle};
      end else if (phase) begin
         gtx_txd <= {tx_sym, tx_hold};
      end
   end

endmodule

// File: design/symbol_link.sv
`timescale 1ns/1ns

module symbol_link (
   input  logic                       cfg_clk,
   input  logic                       rst_n,
   // Receive symbols from the gearbox
   input  eth_link_pkg::line_symbol_t rx_sym,
   input  logic                       rx_sym_valid,
   output logic [7:0]                 rx_byte,
   output logic                       rx_byte_valid,
   output logic                       rx_sof,
   output logic                       rx_eof,
   output logic                       rx_bad,
   // Transmit request, one symbol per handshake
   input  logic                       tx_req,
   input  logic [7:0]                 tx_byte,
   input  logic                       tx_ctl,
   input  logic [3:0]                 tx_ctl_code,
   output logic                       tx_ack,
   output eth_link_pkg::line_symbol_t tx_sym
);

   eth_link_pkg::line_symbol_t tx_next;
   // Symbol of the pending request is on the line
   logic                       tx_sent;

   // ------------------------------------------------------------
   // Receive decode
   // ------------------------------------------------------------

   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         rx_byte_valid <= 1'b0;
         rx_sof        <= 1'b0;
         rx_eof        <= 1'b0;
         rx_bad        <= 1'b0;
      end else begin
         rx_byte_valid <= 1'b0;
         rx_sof        <= 1'b0;
         rx_eof        <= 1'b0;
         rx_bad        <= 1'b0;
         if (rx_sym_valid) begin
            if (!rx_sym.dat.kind) begin
               // Odd count of ones over parity and byte
               if (^{rx_sym.dat.parity, rx_sym.dat.data}) begin
                  rx_byte_valid <= 1'b1;
               end else begin
                  rx_bad <= 1'b1;
               end
            end else if (rx_sym.ctl.spare != 5'd0) begin
               rx_bad <= 1'b1;
            end else begin
               case (rx_sym.ctl.code)
                  eth_link_pkg::ctl_idle: ;
                  eth_link_pkg::ctl_sof:  rx_sof <= 1'b1;
                  eth_link_pkg::ctl_eof:  rx_eof <= 1'b1;
                  default:                rx_bad <= 1'b1;
               endcase
            end
         end
      end
   end

   always_ff @(posedge cfg_clk) begin
      rx_byte <= rx_sym.dat.data;
   end

   // ------------------------------------------------------------
   // Transmit encode
   // ------------------------------------------------------------

   always_comb begin
      if (tx_ctl) begin
         tx_next.ctl.kind  = 1'b1;
         tx_next.ctl.spare = 5'd0;
         tx_next.ctl.code  = tx_ctl_code;
      end else begin
         tx_next.dat.kind   = 1'b0;
         tx_next.dat.parity = ~^tx_byte;
         tx_next.dat.data   = tx_byte;
      end
   end

   // Emit once per request, ack a cycle later, idle otherwise
   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         tx_sym  <= eth_link_pkg::sym_idle;
         tx_sent <= 1'b0;
         tx_ack  <= 1'b0;
      end else if (tx_req && !tx_ack && !tx_sent) begin
         tx_sym  <= tx_next;
         tx_sent <= 1'b1;
      end else begin
         tx_sym <= eth_link_pkg::sym_idle;
         if (tx_sent) begin
            tx_ack  <= 1'b1;
            tx_sent <= 1'b0;
         end else if (!tx_req) begin
            // Requester has let go
            tx_ack <= 1'b0;
         end
      end
   end

endmodule

// File: design/cfg_regs.sv
`timescale 1ns/1ns

module cfg_regs (
   input  logic        cfg_clk,
   input  logic        rst_n,
   input  logic        cfg_valid,
   input  logic [4:0]  cfg_addr,
   input  logic [7:0]  cfg_wdata,
   output logic [31:0] cfg_ip,
   output logic [15:0] cfg_port
);

   // ------------------------------------------------------------
   // Byte writes, index 0 is the top byte
   // ------------------------------------------------------------

   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         // 192.168.7.4
         cfg_ip   <= 32'hc0a8_0704;
         cfg_port <= 16'h0bd4;
      end else if (cfg_valid) begin
         // IP bank
         if (cfg_addr[4] == eth_frame_pkg::sel_ipaddr) begin
            for (int i = 0; i < eth_frame_pkg::ip_bytes; i++) begin
               if (cfg_addr[3:0] == 4'(i)) begin
                  cfg_ip[8*(eth_frame_pkg::ip_bytes-1-i) +: 8] <= cfg_wdata;
               end
            end
         end
         // UDP port bank
         if (cfg_addr[4] == eth_frame_pkg::sel_udp) begin
            for (int i = 0; i < eth_frame_pkg::port_bytes; i++) begin
               if (cfg_addr[3:0] == 4'(i)) begin
                  cfg_port[8*(eth_frame_pkg::port_bytes-1-i) +: 8] <= cfg_wdata;
               end
            end
         end
         // Indices past the bank are dropped
      end
   end

endmodule

// File: design/lb_cmd_engine.sv
`timescale 1ns/1ns

module lb_cmd_engine (
   input  logic        cfg_clk,
   input  logic        rst_n,
   input  logic        cfg_enable_rx,
   input  logic [31:0] cfg_ip,
   input  logic [15:0] cfg_port,
   // Receive side of the symbol link
   input  logic [7:0]  rx_byte,
   input  logic        rx_byte_valid,
   input  logic        rx_sof,
   input  logic        rx_eof,
   input  logic        rx_bad,
   // Transmit handshake
   input  logic        tx_ack,
   output logic        tx_req,
   output logic [7:0]  tx_byte,
   output logic        tx_ctl,
   output logic [3:0]  tx_ctl_code,
   // Local bus
   input  logic [31:0] lb_rdata,
   output logic        lb_valid,
   output logic        lb_rnw,
   output logic [23:0] lb_addr,
   output logic [31:0] lb_wdata,
   output logic        lb_renable,
   output logic        rx_mon,
   output logic        tx_mon
);

   // Incoming frame and outgoing reply, first byte on top
   logic [eth_frame_pkg::frame_w-1:0] fr;
   logic [eth_frame_pkg::frame_w-1:0] rp;
   logic [4:0]                        cnt;
   logic [3:0]                        tx_cnt;
   logic [2:0]                        state;
   logic                              in_frame;
   logic                              addr_ok;
   logic                              accept;
   logic [7:0]                        op_byte;

   // Destination checks
   assign addr_ok =
      (fr[eth_frame_pkg::frame_w - 8*eth_frame_pkg::off_ip - 1 -: 32] == cfg_ip) &&
      (fr[eth_frame_pkg::frame_w - 8*eth_frame_pkg::off_port - 1 -: 16] == cfg_port);
   assign op_byte = fr[eth_frame_pkg::frame_w - 8*eth_frame_pkg::off_op - 1 -: 8];

   assign accept = (state == eth_frame_pkg::st_idle) && in_frame && rx_eof &&
                   cfg_enable_rx && addr_ok && (cnt == 5'(eth_frame_pkg::cmd_len));

   // Fields stay put while tx_req is high
   assign tx_byte     = rp[eth_frame_pkg::frame_w-1 -: 8];
   assign tx_ctl      = (state != eth_frame_pkg::st_data);
   assign tx_ctl_code = (state == eth_frame_pkg::st_sof) ? eth_link_pkg::ctl_sof
                                                        : eth_link_pkg::ctl_eof;

   // ------------------------------------------------------------
   // Frame collection
   // ------------------------------------------------------------

   // SOF restarts, bad symbol aborts, busy drops everything
   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         in_frame <= 1'b0;
         cnt      <= 5'd0;
      end else if (state != eth_frame_pkg::st_idle) begin
         in_frame <= 1'b0;
      end else if (rx_sof) begin
         in_frame <= 1'b1;
         cnt      <= 5'd0;
      end else if (rx_bad || rx_eof) begin
         in_frame <= 1'b0;
      end else if (rx_byte_valid && in_frame && cnt <= 5'(eth_frame_pkg::cmd_len)) begin
         // Saturates one past the frame length
         cnt <= cnt + 5'd1;
      end
   end

   always_ff @(posedge cfg_clk) begin
      if (rx_byte_valid && in_frame && state == eth_frame_pkg::st_idle) begin
         fr <= {fr[eth_frame_pkg::frame_w-9:0], rx_byte};
      end
   end

   // ------------------------------------------------------------
   // Bus cycle and reply sequence
   // ------------------------------------------------------------

   always_ff @(posedge cfg_clk) begin
      if (!rst_n) begin
         state      <= eth_frame_pkg::st_idle;
         tx_req     <= 1'b0;
         tx_cnt     <= 4'd0;
         lb_valid   <= 1'b0;
         lb_renable <= 1'b0;
         lb_rnw     <= 1'b0;
         lb_addr    <= 24'd0;
         lb_wdata   <= 32'd0;
         rx_mon     <= 1'b0;
         tx_mon     <= 1'b0;
      end else begin
         lb_valid   <= 1'b0;
         lb_renable <= 1'b0;
         rx_mon     <= 1'b0;
         tx_mon     <= 1'b0;
         case (state)
            eth_frame_pkg::st_idle: if (accept) begin
               lb_valid   <= 1'b1;
               lb_renable <= op_byte[0];
               lb_rnw     <= op_byte[0];
               lb_addr    <= fr[eth_frame_pkg::frame_w - 8*eth_frame_pkg::off_addr - 1 -: 24];
               lb_wdata   <= fr[eth_frame_pkg::frame_w - 8*eth_frame_pkg::off_data - 1 -: 32];
               rx_mon     <= 1'b1;
               state      <= eth_frame_pkg::st_bus;
            end
            // Strobe cycle
            eth_frame_pkg::st_bus: state <= eth_frame_pkg::st_cap;
            // Read data valid here
            eth_frame_pkg::st_cap: begin
               tx_cnt <= 4'd0;
               state  <= eth_frame_pkg::st_sof;
            end
            eth_frame_pkg::st_sof, eth_frame_pkg::st_data, eth_frame_pkg::st_eof: begin
               if (!tx_req && !tx_ack) begin
                  tx_req <= 1'b1;
               end else if (tx_req && tx_ack) begin
                  tx_req <= 1'b0;
                  if (state == eth_frame_pkg::st_sof) begin
                     state <= eth_frame_pkg::st_data;
                  end else if (state == eth_frame_pkg::st_data) begin
                     tx_cnt <= tx_cnt + 4'd1;
                     if (tx_cnt == 4'(eth_frame_pkg::cmd_len - 1)) begin
                        state <= eth_frame_pkg::st_eof;
                     end
                  end else begin
                     tx_mon <= 1'b1;
                     state  <= eth_frame_pkg::st_idle;
                  end
               end
            end
            default: state <= eth_frame_pkg::st_idle;
         endcase
      end
   end

   // Reply body, IP from config, port to address echoed
   always_ff @(posedge cfg_clk) begin
      if (state == eth_frame_pkg::st_cap) begin
         rp <= {cfg_ip,
                fr[eth_frame_pkg::frame_w - 8*eth_frame_pkg::off_port - 1 :
                   eth_frame_pkg::frame_w - 8*eth_frame_pkg::off_data],
                lb_rnw ? lb_rdata : lb_wdata};
      end else if (state == eth_frame_pkg::st_data && tx_req && tx_ack) begin
         rp <= {rp[eth_frame_pkg::frame_w-9:0], 8'h00};
      end
   end

endmodule

// File: design/eth_gtx_bridge.sv
`timescale 1ns/1ns

module eth_gtx_bridge (
   input  logic        cfg_clk,
   input  logic        rst_n,
   // Transceiver words, low half is the earlier symbol
   input  logic [19:0] gtx_rxd,
   output logic [19:0] gtx_txd,
   // Configuration, cfg_addr[4] picks IP or UDP bank
   input  logic        cfg_enable_rx,
   input  logic        cfg_valid,
   input  logic [4:0]  cfg_addr,
   input  logic [7:0]  cfg_wdata,
   // Local bus
   output logic        lb_valid,
   output logic        lb_rnw,
   output logic [23:0] lb_addr,
   output logic [31:0] lb_wdata,
   output logic        lb_renable,
   input  logic [31:0] lb_rdata,
   // Monitors
   output logic        rx_mon,
   output logic        tx_mon
);

   eth_link_pkg::line_symbol_t rx_sym;
   eth_link_pkg::line_symbol_t tx_sym;
   logic                       rx_sym_valid;
   logic [7:0]                 rx_byte;
   logic                       rx_byte_valid;
   logic                       rx_sof;
   logic                       rx_eof;
   logic                       rx_bad;
   logic                       tx_req;
   logic                       tx_ack;
   logic [7:0]                 tx_byte;
   logic                       tx_ctl;
   logic [3:0]                 tx_ctl_code;
   logic [31:0]                cfg_ip;
   logic [15:0]                cfg_port;

   // Word to symbol rate conversion
   gtx_gearbox u_gearbox (
      .cfg_clk      (cfg_clk),
      .rst_n        (rst_n),
      .gtx_rxd      (gtx_rxd),
      .tx_sym       (tx_sym),
      .gtx_txd      (gtx_txd),
      .rx_sym       (rx_sym),
      .rx_sym_valid (rx_sym_valid)
   );

   // Symbol coding
   symbol_link u_link (
      .cfg_clk       (cfg_clk),
      .rst_n         (rst_n),
      .rx_sym        (rx_sym),
      .rx_sym_valid  (rx_sym_valid),
      .rx_byte       (rx_byte),
      .rx_byte_valid (rx_byte_valid),
      .rx_sof        (rx_sof),
      .rx_eof        (rx_eof),
      .rx_bad        (rx_bad),
      .tx_req        (tx_req),
      .tx_byte       (tx_byte),
      .tx_ctl        (tx_ctl),
      .tx_ctl_code   (tx_ctl_code),
      .tx_ack        (tx_ack),
      .tx_sym        (tx_sym)
   );

   cfg_regs u_cfg (
      .cfg_clk   (cfg_clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_ip    (cfg_ip),
      .cfg_port  (cfg_port)
   );

   // Frame match, bus cycle and reply
   lb_cmd_engine u_engine (
      .cfg_clk       (cfg_clk),
      .rst_n         (rst_n),
      .cfg_enable_rx (cfg_enable_rx),
      .cfg_ip        (cfg_ip),
      .cfg_port      (cfg_port),
      .rx_byte       (rx_byte),
      .rx_byte_valid (rx_byte_valid),
      .rx_sof        (rx_sof),
      .rx_eof        (rx_eof),
      .rx_bad        (rx_bad),
      .tx_ack        (tx_ack),
      .tx_req        (tx_req),
      .tx_byte       (tx_byte),
      .tx_ctl        (tx_ctl),
      .tx_ctl_code   (tx_ctl_code),
      .lb_rdata      (lb_rdata),
      .lb_valid      (lb_valid),
      .lb_rnw        (lb_rnw),
      .lb_addr       (lb_addr),
      .lb_wdata      (lb_wdata),
      .lb_renable    (lb_renable),
      .rx_mon        (rx_mon),
      .tx_mon        (tx_mon)
   );

endmodule

// File: testbench/eth_gtx_bridge_tb.sv
`timescale 1ns/1ns

module eth_gtx_bridge_tb;

   localparam int reply_limit = 400;
   localparam int drop_window = 250;
   // Frame variants
   localparam int k_good     = 0;
   localparam int k_bad_ip   = 1;
   localparam int k_bad_port = 2;
   localparam int k_disabled = 3;
   localparam int k_parity   = 4;
   localparam int k_short    = 5;
   localparam int k_long     = 6;
   localparam int k_cut      = 7;

   logic        cfg_clk;
   logic        rst_n;
   logic [19:0] gtx_rxd;
   logic [19:0] gtx_txd;
   logic        cfg_enable_rx;
   logic        cfg_valid;
   logic [4:0]  cfg_addr;
   logic [7:0]  cfg_wdata;
   logic        lb_valid;
   logic        lb_rnw;
   logic [23:0] lb_addr;
   logic [31:0] lb_wdata;
   logic        lb_renable;
   logic [31:0] lb_rdata;
   logic        rx_mon;
   logic        tx_mon;

   // Cycles since reset, bit 0 follows the DUT word phase
   int unsigned cyc;
   // Bus log entries {rnw, renable, addr, wdata}
   logic [57:0] bus_q [$];
   logic [9:0]  sym_log [$];
   int          rx_mon_n;
   int          tx_mon_n;
   int          stray_n;
   logic [31:0] next_rdata;

   // Model state
   logic [31:0] model_ip;
   logic [15:0] model_port;
   logic [7:0]  frm [$];
   logic [9:0]  sym_q [$];
   int          bus_rd;
   int          sym_rd;
   int          rx_seen;
   int          tx_seen;
   int          err_cnt;
   int          test_err;
   int          pass_n;
   int          fail_n;

   eth_gtx_bridge UUT (
      .cfg_clk       (cfg_clk),
      .rst_n         (rst_n),
      .gtx_rxd       (gtx_rxd),
      .gtx_txd       (gtx_txd),
      .cfg_enable_rx (cfg_enable_rx),
      .cfg_valid     (cfg_valid),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .lb_valid      (lb_valid),
      .lb_rnw        (lb_rnw),
      .lb_addr       (lb_addr),
      .lb_wdata      (lb_wdata),
      .lb_renable    (lb_renable),
      .lb_rdata      (lb_rdata),
      .rx_mon        (rx_mon),
      .tx_mon        (tx_mon)
   );

   initial begin
      cfg_clk = 1'b0;
      forever #5 cfg_clk = ~cfg_clk;
   end

   always @(posedge cfg_clk) begin
      if (!rst_n) begin
         cyc <= 0;
      end else begin
         cyc <= cyc + 1;
      end
   end

   // ------------------------------------------------------------
   // Bus responder and monitor counters
   // ------------------------------------------------------------

   initial begin : bus_responder
      lb_rdata = 32'h0;
      forever begin
         @(posedge cfg_clk);
         if (rst_n === 1'b1) begin
            if (lb_valid) begin
               bus_q.push_back({lb_rnw, lb_renable, lb_addr, lb_wdata});
            end
            // Read data valid only in the cycle after the strobe
            if (lb_valid && lb_rnw) begin
               lb_rdata <= next_rdata;
            end else begin
               lb_rdata <= ~next_rdata;
            end
            if (lb_renable && !lb_valid) begin
               stray_n <= stray_n + 1;
            end
            if (rx_mon) begin
               rx_mon_n <= rx_mon_n + 1;
            end
            if (tx_mon) begin
               tx_mon_n <= tx_mon_n + 1;
            end
         end
      end
   end

   // Reply words are stable on phase-zero cycles, low half first
   initial begin : reply_collector
      forever begin
         @(posedge cfg_clk);
         if (rst_n === 1'b1 && cyc[0] == 1'b0) begin
            if (gtx_txd[9:0] != eth_link_pkg::sym_idle) begin
               sym_log.push_back(gtx_txd[9:0]);
            end
            if (gtx_txd[19:10] != eth_link_pkg::sym_idle) begin
               sym_log.push_back(gtx_txd[19:10]);
            end
         end
      end
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------

   task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                              input string what);
      if (got !== want) begin
         $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, want);
         err_cnt++;
      end
   endtask

   // Odd parity over parity bit and byte
   function automatic logic [9:0] data_sym(input logic [7:0] b);
      return {1'b0, ~^b, b};
   endfunction

   function automatic logic [9:0] ctl_sym(input logic [3:0] code);
      return {1'b1, 5'b00000, code};
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge cfg_clk);
   endtask

   // Next edge after a drive slot captures the word
   task automatic drive_word(input logic [19:0] w);
      int guard;
      @(posedge cfg_clk);
      for (guard = 0; guard < 2 && cyc[0] != 1'b1; guard++) begin
         @(posedge cfg_clk);
      end
      gtx_rxd <= w;
   endtask

   task automatic send_symbols();
      logic [9:0] lo;
      logic [9:0] hi;
      while (sym_q.size() > 0) begin
         lo = sym_q.pop_front();
         hi = eth_link_pkg::sym_idle;
         if (sym_q.size() > 0) begin
            hi = sym_q.pop_front();
         end
         drive_word({hi, lo});
      end
      drive_word({eth_link_pkg::sym_idle, eth_link_pkg::sym_idle});
   endtask

   task automatic cfg_write(input logic [4:0] addr, input logic [7:0] data);
      @(posedge cfg_clk);
      cfg_valid <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      @(posedge cfg_clk);
      cfg_valid <= 1'b0;
   endtask

   // Command addressed to the configured IP and port
   task automatic make_frame(input logic rnw);
      logic [31:0] r;
      int          i;
      frm.delete();
      for (i = 0; i < eth_frame_pkg::ip_bytes; i++) begin
         frm.push_back(8'(model_ip >> (8 * (3 - i))));
      end
      frm.push_back(model_port[15:8]);
      frm.push_back(model_port[7:0]);
      r = $urandom();
      frm.push_back({r[7:1], rnw});
      for (i = eth_frame_pkg::off_addr; i < eth_frame_pkg::cmd_len; i++) begin
         frm.push_back(8'($urandom()));
      end
   endtask

   task automatic load_symbols(input int kind);
      logic [9:0] s;
      int         i;
      int         flip_at;
      flip_at = $urandom_range(13, 0);
      sym_q.delete();
      sym_q.push_back(ctl_sym(eth_link_pkg::ctl_sof));
      for (i = 0; i < eth_frame_pkg::cmd_len; i++) begin
         s = data_sym(frm[i]);
         if (kind == k_parity && i == flip_at) begin
            s[8] = ~s[8];
         end
         // Second SOF leaves only the tail in the frame
         if (kind == k_cut && i == 7) begin
            sym_q.push_back(ctl_sym(eth_link_pkg::ctl_sof));
         end
         if (!(kind == k_short && i == eth_frame_pkg::cmd_len - 1)) begin
            sym_q.push_back(s);
         end
      end
      if (kind == k_long) begin
         sym_q.push_back(data_sym(8'($urandom())));
      end
      sym_q.push_back(ctl_sym(eth_link_pkg::ctl_eof));
   endtask

   task automatic wait_reply(output bit seen);
      int guard;
      seen = 1'b0;
      for (guard = 0; guard < reply_limit && !seen; guard++) begin
         @(posedge cfg_clk);
         if (tx_mon_n != tx_seen) begin
            seen = 1'b1;
         end
      end
      if (!seen) begin
         $display("timeout: no reply frame within %0d cycles at %0t", reply_limit, $time);
         err_cnt++;
      end
      // Last reply word still on its way to the collector
      wait_cycles(6);
   endtask

   task automatic check_reply(input logic [31:0] data);
      logic [7:0] want [$];
      logic [9:0] s;
      int         i;
      for (i = 0; i < eth_frame_pkg::ip_bytes; i++) begin
         want.push_back(8'(model_ip >> (8 * (3 - i))));
      end
      // Port, op and address echoed
      for (i = eth_frame_pkg::off_port; i < eth_frame_pkg::off_data; i++) begin
         want.push_back(frm[i]);
      end
      for (i = 0; i < 4; i++) begin
         want.push_back(8'(data >> (8 * (3 - i))));
      end
      check_value(sym_log.size() - sym_rd, eth_frame_pkg::cmd_len + 2, "reply symbol count");
      if (sym_log.size() - sym_rd == eth_frame_pkg::cmd_len + 2) begin
         check_value(32'(sym_log[sym_rd]), 32'(ctl_sym(eth_link_pkg::ctl_sof)), "reply SOF");
         for (i = 0; i < eth_frame_pkg::cmd_len; i++) begin
            s = sym_log[sym_rd + 1 + i];
            check_value(32'(^s[8:0]), 32'd1, $sformatf("reply byte %0d parity", i));
            check_value(32'(s), 32'(data_sym(want[i])), $sformatf("reply byte %0d", i));
         end
         check_value(32'(sym_log[sym_rd + eth_frame_pkg::cmd_len + 1]),
                     32'(ctl_sym(eth_link_pkg::ctl_eof)), "reply EOF");
      end
   endtask

   task automatic sync_counts();
      bus_rd  = bus_q.size();
      sym_rd  = sym_log.size();
      rx_seen = rx_mon_n;
      tx_seen = tx_mon_n;
   endtask

   // ------------------------------------------------------------
   // Frame runs
   // ------------------------------------------------------------

   task automatic run_command(input logic rnw);
      logic [57:0] e;
      logic [31:0] data;
      bit          seen;
      make_frame(rnw);
      next_rdata = $urandom();
      load_symbols(k_good);
      send_symbols();
      wait_reply(seen);
      if (seen) begin
         data = rnw ? next_rdata : {frm[10], frm[11], frm[12], frm[13]};
         check_value(bus_q.size() - bus_rd, 1, "bus cycles per frame");
         check_value(rx_mon_n - rx_seen, 1, "rx_mon pulses per frame");
         check_value(tx_mon_n - tx_seen, 1, "tx_mon pulses per reply");
         if (bus_q.size() > bus_rd) begin
            e = bus_q[bus_rd];
            check_value(32'(e[57]), 32'(rnw), "lb_rnw");
            check_value(32'(e[56]), 32'(rnw), "lb_renable with strobe");
            check_value(32'(e[55:32]), 32'({frm[7], frm[8], frm[9]}), "lb_addr");
            if (!rnw) begin
               check_value(e[31:0], data, "lb_wdata");
            end
         end
         check_reply(data);
      end
      sync_counts();
   endtask

   // Frame that must leave no trace on the bus or the line
   task automatic run_dropped(input int kind);
      int r;
      make_frame(1'($urandom_range(1, 0)));
      next_rdata = $urandom();
      if (kind == k_bad_ip) begin
         r = $urandom_range(3, 0);
         frm[r] = frm[r] ^ 8'($urandom_range(255, 1));
      end else if (kind == k_bad_port) begin
         r = eth_frame_pkg::off_port + $urandom_range(1, 0);
         frm[r] = frm[r] ^ 8'($urandom_range(255, 1));
      end else if (kind == k_disabled) begin
         @(posedge cfg_clk);
         cfg_enable_rx <= 1'b0;
      end
      load_symbols(kind);
      send_symbols();
      wait_cycles(drop_window);
      check_value(bus_q.size() - bus_rd, 0, $sformatf("bus cycle on dropped frame %0d", kind));
      check_value(rx_mon_n - rx_seen, 0, $sformatf("rx_mon on dropped frame %0d", kind));
      check_value(tx_mon_n - tx_seen, 0, $sformatf("tx_mon on dropped frame %0d", kind));
      check_value(sym_log.size() - sym_rd, 0, $sformatf("reply to dropped frame %0d", kind));
      if (kind == k_disabled) begin
         @(posedge cfg_clk);
         cfg_enable_rx <= 1'b1;
      end
      sync_counts();
   endtask

   task automatic begin_test();
      test_err = err_cnt;
   endtask

   task automatic end_test(input string name);
      if (err_cnt == test_err) begin
         pass_n++;
         $display("test %s: pass", name);
      end else begin
         fail_n++;
         $display("test %s: FAIL with %0d errors", name, err_cnt - test_err);
      end
   endtask

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------

   initial begin : test_seq
      int i;
      rst_n         = 1'b0;
      gtx_rxd       = {eth_link_pkg::sym_idle, eth_link_pkg::sym_idle};
      cfg_enable_rx = 1'b0;
      cfg_valid     = 1'b0;
      cfg_addr      = 5'd0;
      cfg_wdata     = 8'd0;
      next_rdata    = 32'd0;
      void'($urandom(32'h1f02));
      // Reset values of the config registers
      model_ip   = 32'hc0a8_0704;
      model_port = 16'h0bd4;
      repeat (5) @(posedge cfg_clk);
      rst_n <= 1'b1;

      begin_test();
      for (i = 0; i < 40; i++) begin
         @(posedge cfg_clk);
         check_value(32'({lb_valid, lb_renable, rx_mon, tx_mon}), 32'd0, "outputs after reset");
         check_value(32'(gtx_txd), 32'({eth_link_pkg::sym_idle, eth_link_pkg::sym_idle}),
                     "line after reset");
      end
      check_value(sym_log.size(), 0, "reply symbols before any frame");
      end_test("reset and idle");
      @(posedge cfg_clk);
      cfg_enable_rx <= 1'b1;

      begin_test();
      model_ip   = $urandom();
      model_port = 16'($urandom());
      for (i = 0; i < eth_frame_pkg::ip_bytes; i++) begin
         cfg_write({eth_frame_pkg::sel_ipaddr, 4'(i)}, 8'(model_ip >> (8 * (3 - i))));
      end
      for (i = 0; i < eth_frame_pkg::port_bytes; i++) begin
         cfg_write({eth_frame_pkg::sel_udp, 4'(i)}, 8'(model_port >> (8 * (1 - i))));
      end
      // Indices past each bank change nothing
      cfg_write({eth_frame_pkg::sel_ipaddr, 4'd5}, 8'($urandom()));
      cfg_write({eth_frame_pkg::sel_udp, 4'd3}, 8'($urandom()));
      for (i = 0; i < 8; i++) begin
         run_command(1'b0);
      end
      end_test("config and random writes");

      begin_test();
      for (i = 0; i < 8; i++) begin
         run_command(1'b1);
      end
      end_test("random reads");

      begin_test();
      for (i = 0; i < 2; i++) begin
         run_dropped(k_bad_ip);
         run_dropped(k_bad_port);
         run_dropped(k_disabled);
      end
      end_test("filtering");

      begin_test();
      for (i = k_parity; i <= k_cut; i++) begin
         run_dropped(i);
         run_command(1'($urandom_range(1, 0)));
      end
      end_test("malformed frames");

      begin_test();
      for (i = 0; i < 8; i++) begin
         run_command(1'($urandom_range(1, 0)));
      end
      // Quiet line once the last reply is out
      wait_cycles(100);
      check_value(sym_log.size() - sym_rd, 0, "symbols between replies");
      check_value(bus_q.size() - bus_rd, 0, "bus cycles while idle");
      check_value(stray_n, 0, "lb_renable without lb_valid");
      end_test("reply framing");

      $display("tests passed %0d, failed %0d, errors %0d", pass_n, fail_n, err_cnt);
      if (fail_n == 0 && err_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: src.f
design/eth_link_pkg.sv
design/eth_frame_pkg.sv
design/gtx_gearbox.sv
design/symbol_link.sv
design/cfg_regs.sv
design/lb_cmd_engine.sv
design/eth_gtx_bridge.sv
testbench/eth_gtx_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -f src.f --top-module eth_gtx_bridge_tb \
   -Mdir obj_dir -o eth_gtx_bridge_sim > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
   cat "$build_log"
   echo "Verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/eth_gtx_bridge_sim > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"
if [ $run_status -ne 0 ]; then
   echo "Simulation run returned status $run_status"
   exit 1
fi

if grep -q "Simulation failed" "$sim_log"; then
   exit 1
fi
exit 0
